/* rtl/execPkg.sv */
package execPkg;

  // Data byte width of the core
  localparam int byteW = 8;

  // Register pair width, high byte over low byte
  localparam int pairW = 16;

  // Pair index width, shared by logical and physical pair numbers
  localparam int pairAddrW = 3;

  // Logical pair codes as seen by a command
  // Codes 4 to 6 address the alternate BC', DE' and HL' directly
  localparam logic [pairAddrW-1:0] pairBC = 3'd0;
  localparam logic [pairAddrW-1:0] pairDE = 3'd1;
  localparam logic [pairAddrW-1:0] pairHL = 3'd2;
  localparam logic [pairAddrW-1:0] pairIX = 3'd3;
  localparam logic [pairAddrW-1:0] pairIY = 3'd7;

  // Command opcodes
  // The ALU ops compute dst = dst op src on single bytes
  // The 16-bit ops step a whole pair by one
  typedef enum logic [3:0] {
    opNop,
    opLdi,
    opMov,
    opAdd,
    opSub,
    opAnd,
    opOr,
    opXor,
    opInc16,
    opDec16,
    opExx
  } opT;

  // One command as presented on the strobe
  // The Hi bits pick the high byte of the named pair, else the low byte
  typedef struct packed {
    opT                   op;
    logic [pairAddrW-1:0] dstPair;
    logic                 dstHi;
    logic [pairAddrW-1:0] srcPair;
    logic                 srcHi;
    logic [byteW-1:0]     imm;
  } cmdT;

  // Flag register, a subset of the Z80 F register
  typedef struct packed {
    logic sign;
    logic zero;
    logic carry;
  } flagT;

  // Result returned with the done pulse
  typedef struct packed {
    logic [pairW-1:0] value;
    flagT             flags;
  } resT;

endpackage

/* rtl/regFile.sv */
`timescale 1ns/100ps

// Eight register pairs held as separate high and low byte banks
// Port A doubles as the write address
module regFile
  import execPkg::*;
(
  input  logic                 clk,
  input  logic                 cen,
  input  logic                 weH,
  input  logic                 weL,
  input  logic [byteW-1:0]     dIH,
  input  logic [byteW-1:0]     dIL,
  input  logic [pairAddrW-1:0] addrA,
  input  logic [pairAddrW-1:0] addrB,
  input  logic [pairAddrW-1:0] addrC,
  output logic [byteW-1:0]     doAH,
  output logic [byteW-1:0]     doAL,
  output logic [byteW-1:0]     doBH,
  output logic [byteW-1:0]     doBL,
  output logic [byteW-1:0]     doCH,
  output logic [byteW-1:0]     doCL
);

  // High and low byte of each physical pair, indexed by pair number
  logic [byteW-1:0] regsH [8];
  logic [byteW-1:0] regsL [8];

  // Writes land on the clock edge, each byte under its own enable
  always_ff @(posedge clk)
  begin
    if (cen)
    begin
      if (weH)
        regsH[addrA] <= dIH;
      if (weL)
        regsL[addrA] <= dIL;
    end
  end

  // All three read ports are combinational
  assign doAH = regsH[addrA];
  assign doAL = regsL[addrA];
  assign doBH = regsH[addrB];
  assign doBL = regsL[addrB];
  assign doCH = regsH[addrC];
  assign doCL = regsL[addrC];

endmodule

/* rtl/aluUnit.sv */
`timescale 1ns/100ps

// Byte ALU for the register slice
// Purely combinational, the caller decides whether the flags are kept
module aluUnit
  import execPkg::*;
(
  input  opT               op,
  input  logic [byteW-1:0] aBus,
  input  logic [byteW-1:0] bBus,
  output logic [byteW-1:0] yBus,
  output flagT             flagsOut
);

  // One extra bit on the sum and difference catches carry and borrow
  logic [byteW:0]   sum9;
  logic [byteW:0]   diff9;
  logic [byteW-1:0] yInt;
  logic             carryOut;

  always_comb
  begin
    sum9     = {1'b0, aBus} + {1'b0, bBus};
    diff9    = {1'b0, aBus} - {1'b0, bBus};

    // Loads and copies just pass the source byte through
    yInt     = bBus;
    carryOut = 1'b0;

    case (op)
      opAdd:
      begin
        yInt     = sum9[byteW-1:0];
        carryOut = sum9[byteW];
      end
      opSub:
      begin
        // The top bit of the difference is set exactly when aBus < bBus
        yInt     = diff9[byteW-1:0];
        carryOut = diff9[byteW];
      end
      opAnd:
      begin
        yInt = aBus & bBus;
      end
      opOr:
      begin
        yInt = aBus | bBus;
      end
      opXor:
      begin
        yInt = aBus ^ bBus;
      end
      default:
      begin
        yInt = bBus;
      end
    endcase
  end

  assign yBus = yInt;

  // Sign is the top bit of the byte, zero when every bit is clear
  // Logic ops leave carryOut at zero, which clears carry
  assign flagsOut.sign  = yInt[byteW-1];
  assign flagsOut.zero  = (yInt == '0);
  assign flagsOut.carry = carryOut;

endmodule

/* rtl/pairArith.sv */
`timescale 1ns/100ps

// Pair incrementer and decrementer
// On a Z80 this unit sits apart from the byte ALU, so INC rr and DEC rr
// never touch the flags and can run beside an 8-bit operation
module pairArith
  import execPkg::*;
(
  input  logic             decr,
  input  logic [pairW-1:0] pairIn,
  output logic [pairW-1:0] pairOut
);

  // Step added to the pair
  // All ones is minus one in two's complement, so a single adder serves
  // both directions
  logic [pairW-1:0] step;

  always_comb
  begin
    if (decr)
    begin
      step = '1;
    end
    else
    begin
      step = pairW'(1);
    end
  end

  // The carry out of the top bit is dropped, so FFFF steps up to 0000
  // and 0000 steps down to FFFF
  assign pairOut = pairIn + step;

endmodule

/* rtl/execCtrl.sv */
`timescale 1ns/100ps

// Command register, EXX bank mapping and write-back control
// A command strobed at edge N executes during the next cycle and retires at N+1
module execCtrl
  import execPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmdValid,
  input  cmdT                  cmd,
  input  logic [pairAddrW-1:0] addrSel,
  output logic [pairAddrW-1:0] addrA,
  output logic [pairAddrW-1:0] addrB,
  output logic [pairAddrW-1:0] addrC,
  output logic                 weH,
  output logic                 weL,
  output logic                 cen,
  output logic [byteW-1:0]     dIH,
  output logic [byteW-1:0]     dIL,
  input  logic [byteW-1:0]     doAH,
  input  logic [byteW-1:0]     doAL,
  input  logic [byteW-1:0]     doBH,
  input  logic [byteW-1:0]     doBL,
  output opT                   aluOp,
  output logic [byteW-1:0]     aluA,
  output logic [byteW-1:0]     aluB,
  input  logic [byteW-1:0]     aluY,
  input  flagT                 aluFlags,
  output logic                 decr,
  output logic [pairW-1:0]     pairIn,
  input  logic [pairW-1:0]     pairOut,
  output logic                 done,
  output resT                  result,
  output logic                 bankSel
);

  cmdT              cmdQ;
  logic             cmdQValid;
  logic [pairW-1:0] valueQ;
  logic [pairW-1:0] resValue;
  flagT             flagQ;
  logic             isByteOp;
  logic             isAluOp;
  logic             isPairOp;

  // EXX flips the top index bit of BC, DE and HL, IX and IY stay put
  function automatic logic [pairAddrW-1:0] mapPair(
    input logic [pairAddrW-1:0] logical,
    input logic                 bank
  );
    logic [pairAddrW-1:0] physical;
    physical = logical;
    if (logical != pairIX && logical != pairIY)
      physical[pairAddrW-1] = logical[pairAddrW-1] ^ bank;
    return physical;
  endfunction

  // Sort the opcode into the three write-back classes
  always_comb
  begin
    isByteOp = 1'b0;
    isAluOp  = 1'b0;
    isPairOp = 1'b0;
    case (cmdQ.op)
      opLdi, opMov:
      begin
        isByteOp = 1'b1;
      end
      opAdd, opSub, opAnd, opOr, opXor:
      begin
        isByteOp = 1'b1;
        isAluOp  = 1'b1;
      end
      opInc16, opDec16:
      begin
        isPairOp = 1'b1;
      end
      default:
      begin
        isByteOp = 1'b0;
      end
    endcase
  end

  // Port A holds the destination, port B the source, port C the bus address
  assign addrA = mapPair(cmdQ.dstPair, bankSel);
  assign addrB = mapPair(cmdQ.srcPair, bankSel);
  assign addrC = mapPair(addrSel, bankSel);

  // An immediate load reaches the ALU on the B side and passes through
  assign aluOp  = cmdQ.op;
  assign aluA   = cmdQ.dstHi ? doAH : doAL;
  assign aluB   = (cmdQ.op == opLdi) ? cmdQ.imm
                                     : (cmdQ.srcHi ? doBH : doBL);
  assign decr   = (cmdQ.op == opDec16);
  assign pairIn = {doAH, doAL};

  // Byte ops write one half of the destination, pair ops write both
  assign cen = cmdQValid;
  assign weH = cmdQValid & (isPairOp | (isByteOp & cmdQ.dstHi));
  assign weL = cmdQValid & (isPairOp | (isByteOp & ~cmdQ.dstHi));
  assign dIH = isPairOp ? pairOut[pairW-1:byteW] : aluY;
  assign dIL = isPairOp ? pairOut[byteW-1:0] : aluY;

  // Value reported with done, zero for EXX and NOP
  assign resValue = isPairOp ? pairOut : (isByteOp ? {{byteW{1'b0}}, aluY} : '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cmdQValid <= 1'b0;
      done      <= 1'b0;
      bankSel   <= 1'b0;
      flagQ     <= '0;
    end
    else
    begin
      cmdQValid <= cmdValid;
      done      <= cmdQValid;
      if (cmdQValid && cmdQ.op == opExx)
        bankSel <= ~bankSel;
      // Only the byte ALU ops change the flags
      if (cmdQValid && isAluOp)
        flagQ <= aluFlags;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmdValid)
      cmdQ <= cmd;
    if (cmdQValid)
      valueQ <= resValue;
  end

  assign result = '{value: valueQ, flags: flagQ};

endmodule

/* rtl/execCore.sv */
`timescale 1ns/100ps

// Register and execute slice of the CPU core
// Control, register file, byte ALU and pair unit wired together
module execCore
  import execPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmdValid,
  input  cmdT                  cmd,
  input  logic [pairAddrW-1:0] addrSel,
  output logic                 done,
  output resT                  result,
  output logic                 bankSel,
  output logic [pairW-1:0]     busAddr
);

  // Register file side
  logic [pairAddrW-1:0] addrA;
  logic [pairAddrW-1:0] addrB;
  logic [pairAddrW-1:0] addrC;
  logic                 weH;
  logic                 weL;
  logic                 cen;
  logic [byteW-1:0]     dIH;
  logic [byteW-1:0]     dIL;
  logic [byteW-1:0]     doAH;
  logic [byteW-1:0]     doAL;
  logic [byteW-1:0]     doBH;
  logic [byteW-1:0]     doBL;
  logic [byteW-1:0]     doCH;
  logic [byteW-1:0]     doCL;

  // ALU and pair unit side
  opT                   aluOp;
  logic [byteW-1:0]     aluA;
  logic [byteW-1:0]     aluB;
  logic [byteW-1:0]     aluY;
  flagT                 aluFlags;
  logic                 decr;
  logic [pairW-1:0]     pairIn;
  logic [pairW-1:0]     pairOut;

  execCtrl i_execCtrl (
    .clk, .rst, .cmdValid, .cmd, .addrSel,
    .addrA, .addrB, .addrC, .weH, .weL, .cen, .dIH, .dIL,
    .doAH, .doAL, .doBH, .doBL,
    .aluOp, .aluA, .aluB, .aluY, .aluFlags,
    .decr, .pairIn, .pairOut,
    .done, .result, .bankSel
  );

  regFile i_regFile (
    .clk, .cen, .weH, .weL, .dIH, .dIL,
    .addrA, .addrB, .addrC,
    .doAH, .doAL, .doBH, .doBL, .doCH, .doCL
  );

  aluUnit i_aluUnit (
    .op(aluOp), .aBus(aluA), .bBus(aluB), .yBus(aluY), .flagsOut(aluFlags)
  );

  pairArith i_pairArith (
    .decr, .pairIn, .pairOut
  );

  // Port C follows the current register contents with no register stage
  assign busAddr = {doCH, doCL};

endmodule

/* verif/execCoreTb.sv */
`timescale 1ns/100ps

module execCoreTb
  import execPkg::*;
();

  logic                 clk;
  logic                 rst;
  logic                 cmdValid;
  cmdT                  cmd;
  logic [pairAddrW-1:0] addrSel;
  logic                 done;
  resT                  result;
  logic                 bankSel;
  logic [pairW-1:0]     busAddr;

  // Reference state: physical pairs, bank bit and flags
  logic [byteW-1:0]     modelH [8];
  logic [byteW-1:0]     modelL [8];
  logic                 modelBank;
  flagT                 modelFlags;

  // Command in flight and the expected outcome of the one retiring now
  logic                 inFlight;
  cmdT                  heldCmd;
  logic                 expDone;
  resT                  expRes;
  logic [pairW-1:0]     expAddr;
  logic                 busCheckOn;
  int                   errorCount;
  int                   checkCount;

  execCore i_dut (
    .clk, .rst, .cmdValid, .cmd, .addrSel,
    .done, .result, .bankSel, .busAddr
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // IX and IY are fixed, the other codes flip their top bit with the bank
  function automatic logic [pairAddrW-1:0] physPair(input logic [pairAddrW-1:0] logical,
                                                    input logic bank);
    if (logical == pairIX || logical == pairIY)
      return logical;
    return {logical[2] ^ bank, logical[1:0]};
  endfunction

  // Applies one command to the model and returns the result it must report
  function automatic resT refStep(input cmdT c);
    logic [pairAddrW-1:0] d;
    logic [pairAddrW-1:0] s;
    logic [byteW-1:0]     a;
    logic [byteW-1:0]     b;
    logic [byteW-1:0]     y;
    logic [pairW-1:0]     p;
    resT                  r;
    d = physPair(c.dstPair, modelBank);
    s = physPair(c.srcPair, modelBank);
    a = c.dstHi ? modelH[d] : modelL[d];
    b = c.srcHi ? modelH[s] : modelL[s];
    y = 8'h00;
    p = {modelH[d], modelL[d]};
    r.value = 16'h0000;
    case (c.op)
      opLdi: y = c.imm;
      opMov: y = b;
      opAdd:
      begin
        y = a + b;
        modelFlags.carry = ({1'b0, a} + {1'b0, b}) > 9'h0ff;
      end
      opSub:
      begin
        // Borrow whenever the subtrahend is the larger byte
        y = a - b;
        modelFlags.carry = a < b;
      end
      opAnd: y = a & b;
      opOr: y = a | b;
      opXor: y = a ^ b;
      opInc16: p = p + 16'd1;
      opDec16: p = p - 16'd1;
      opExx: modelBank = ~modelBank;
      default: y = 8'h00;
    endcase
    if (c.op inside {opAnd, opOr, opXor})
      modelFlags.carry = 1'b0;
    if (c.op inside {opAdd, opSub, opAnd, opOr, opXor})
    begin
      modelFlags.sign = y[7];
      modelFlags.zero = (y == 8'h00);
    end
    if (c.op inside {opLdi, opMov, opAdd, opSub, opAnd, opOr, opXor})
    begin
      if (c.dstHi)
        modelH[d] = y;
      else
        modelL[d] = y;
      r.value = {8'h00, y};
    end
    if (c.op inside {opInc16, opDec16})
    begin
      modelH[d] = p[15:8];
      modelL[d] = p[7:0];
      r.value = p;
    end
    r.flags = modelFlags;
    return r;
  endfunction

  function automatic cmdT makeCmd(input opT op, input logic [2:0] dp, input logic dh,
                                  input logic [2:0] sp, input logic sh, input logic [7:0] imm);
    cmdT c;
    c.op = op;
    c.dstPair = dp;
    c.dstHi = dh;
    c.srcPair = sp;
    c.srcHi = sh;
    c.imm = imm;
    return c;
  endfunction

  function automatic cmdT randomCmd(input opT op);
    return makeCmd(op, 3'($urandom), 1'($urandom), 3'($urandom), 1'($urandom), 8'($urandom));
  endfunction

  // Strobes one command, the bus address pair is picked at random each cycle
  task automatic issue(input cmdT c);
    cmd = c;
    cmdValid = 1'b1;
    addrSel = 3'($urandom);
    @(posedge clk);
    #1;
  endtask

  // Quiet cycles carry garbage on cmd, which must be ignored
  task automatic idleCycles(input int n);
    repeat (n)
    begin
      cmdValid = 1'b0;
      cmd = randomCmd(opT'(4'($urandom_range(10, 0))));
      addrSel = 3'($urandom);
      @(posedge clk);
      #1;
    end
  endtask

  // Lets the last command retire, giving up after a bounded number of cycles
  task automatic drain();
    int waitCount;
    waitCount = 0;
    cmdValid = 1'b0;
    while ((inFlight || expDone) && waitCount < 10)
    begin
      @(posedge clk);
      #1;
      waitCount++;
    end
    if (inFlight || expDone)
    begin
      $display("ERROR at %0t: commands still outstanding after the drain timeout", $time);
      errorCount++;
    end
  endtask

  task automatic reportMismatch(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    errorCount++;
  endtask

  // The model steps on the edge where the DUT writes back
  always @(posedge clk)
  begin
    if (rst)
    begin
      inFlight = 1'b0;
      expDone = 1'b0;
      modelBank = 1'b0;
      modelFlags = '0;
    end
    else
    begin
      expDone = inFlight;
      if (inFlight)
        expRes = refStep(heldCmd);
      inFlight = cmdValid;
      heldCmd = cmd;
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkCount++;
      if (done !== expDone)
      begin
        if (expDone)
          $display("ERROR at %0t: done missing one cycle after a strobe", $time);
        else
          $display("ERROR at %0t: done pulsed with no command strobed", $time);
        errorCount++;
      end
      else if (expDone)
      begin
        if (result.value !== expRes.value)
          reportMismatch("result.value", result.value, expRes.value);
        if (result.flags !== expRes.flags)
          reportMismatch("result.flags", {13'd0, result.flags}, {13'd0, expRes.flags});
      end
      if (bankSel !== modelBank)
        reportMismatch("bankSel", {15'd0, bankSel}, {15'd0, modelBank});
      // Registers power up unknown, so the bus is only compared once all are loaded
      if (busCheckOn)
      begin
        expAddr = {modelH[physPair(addrSel, modelBank)], modelL[physPair(addrSel, modelBank)]};
        if (busAddr !== expAddr)
          reportMismatch("busAddr", busAddr, expAddr);
      end
    end
  end

  initial
  begin
    int p;
    void'($urandom(32'hab68));
    errorCount = 0;
    checkCount = 0;
    busCheckOn = 1'b0;
    rst = 1'b1;
    cmdValid = 1'b0;
    cmd = makeCmd(opNop, 3'd0, 1'b0, 3'd0, 1'b0, 8'h00);
    addrSel = 3'd0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    if (result.flags !== 3'b000)
      reportMismatch("result.flags", {13'd0, result.flags}, 16'h0000);

    // With the bank at 0 the logical codes reach every physical pair
    for (p = 0; p < 8; p++)
    begin
      issue(makeCmd(opLdi, 3'(p), 1'b1, 3'd0, 1'b0, 8'($urandom)));
      issue(makeCmd(opLdi, 3'(p), 1'b0, 3'd0, 1'b0, 8'($urandom)));
    end
    drain();
    busCheckOn = 1'b1;
    repeat (16) issue(randomCmd(opMov));

    // Carry out of FF+1 and borrow out of 0-1
    issue(makeCmd(opLdi, pairBC, 1'b0, 3'd0, 1'b0, 8'hff));
    issue(makeCmd(opLdi, pairDE, 1'b0, 3'd0, 1'b0, 8'h01));
    issue(makeCmd(opAdd, pairBC, 1'b0, pairDE, 1'b0, 8'h00));
    issue(makeCmd(opLdi, pairHL, 1'b0, 3'd0, 1'b0, 8'h00));
    issue(makeCmd(opSub, pairHL, 1'b0, pairDE, 1'b0, 8'h00));
    repeat (60) issue(randomCmd(opT'(4'($urandom_range(7, 3)))));

    // Pair wrap in both directions, the flags must hold
    issue(makeCmd(opLdi, pairIX, 1'b1, 3'd0, 1'b0, 8'hff));
    issue(makeCmd(opLdi, pairIX, 1'b0, 3'd0, 1'b0, 8'hff));
    issue(makeCmd(opInc16, pairIX, 1'b0, 3'd0, 1'b0, 8'h00));
    issue(makeCmd(opDec16, pairIX, 1'b0, 3'd0, 1'b0, 8'h00));

    // Alternate set is written and read, then swapped back
    issue(makeCmd(opExx, 3'd0, 1'b0, 3'd0, 1'b0, 8'h00));
    issue(makeCmd(opLdi, pairHL, 1'b1, 3'd0, 1'b0, 8'h5a));
    issue(makeCmd(opMov, pairBC, 1'b0, pairIY, 1'b1, 8'h00));
    idleCycles(3);
    issue(makeCmd(opExx, 3'd0, 1'b0, 3'd0, 1'b0, 8'h00));

    // A chain on one byte, every step depends on the one before
    repeat (8) issue(makeCmd(opAdd, pairHL, 1'b0, pairDE, 1'b0, 8'h00));

    // Mixed traffic with quiet gaps of random length
    repeat (150)
    begin
      issue(randomCmd(opT'(4'($urandom_range(10, 0)))));
      if ($urandom_range(3, 0) == 0)
        idleCycles(1 + $urandom_range(2, 0));
    end
    drain();

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* tb.f */
rtl/execPkg.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/pairArith.sv
rtl/execCtrl.sv
rtl/execCore.sv
verif/execCoreTb.sv

/* Makefile */
SIM        = verilator
TOP        = execCoreTb
FILELIST   = tb.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -Fqx '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
